/* logic/copper_pkg.sv */
/*
 * copper package
 * widths, opcodes, host address map and the two decode views of one
 * 32-bit copper instruction (high word in even bank, low word in odd bank)
 */

package copper_pkg;

    // one program memory word, also the APB data width
    typedef logic [15:0] word_t;

    // bank address width, 512 entries per bank
    localparam int COP_AWIDTH = 9;
    // video register address width
    localparam int REG_AWIDTH = 14;
    // width of each beam coordinate
    localparam int BEAM_WIDTH = 10;
    // APB byte address width
    localparam int APB_AWIDTH = 12;

    // opcode sits in bits 1:0 of the low word
    // 2'b00 is reserved and skipped as a no-op
    typedef enum logic [1:0] {
        COP_NOP  = 2'b00,
        COP_MOVE = 2'b01,
        COP_WAIT = 2'b10,
        COP_END  = 2'b11
    } cop_op_e;

    // move view: data word, register address, opcode
    typedef struct packed {
        word_t                 data;
        logic [REG_AWIDTH-1:0] reg_addr;
        cop_op_e               op;
    } cop_move_t;

    // wait view: target beam position, spare bits, opcode
    typedef struct packed {
        logic [BEAM_WIDTH-1:0]   v_pos;
        logic [BEAM_WIDTH-1:0]   h_pos;
        logic [29-2*BEAM_WIDTH:0] rsvd;
        cop_op_e                 op;
    } cop_wait_t;

    // one instruction word as {even bank, odd bank}
    typedef union packed {
        cop_move_t move_view;
        cop_wait_t wait_view;
    } cop_instr_u;

    // fill values so an untouched entry decodes as END
    localparam word_t END_WORD_EVEN = 16'h0000;
    localparam word_t END_WORD_ODD  = 16'h0003;

    // address map: bit 11 low selects program memory, bit 1 picks the half
    localparam int MEM_SEL_BIT  = 11;
    localparam int HALF_SEL_BIT = 1;
    localparam logic [APB_AWIDTH-1:0] CTRL_ADDR   = 12'h800;
    localparam logic [APB_AWIDTH-1:0] STATUS_ADDR = 12'h804;

endpackage

/* logic/copper_mem_if.sv */
/*
 * copper memory link
 * joins one program bank to the APB writer and the engine reader
 */

`timescale 1ns/1ps

interface copper_mem_if;

    // write side, one strobe per committed word
    logic                              wr_en;
    logic [copper_pkg::COP_AWIDTH-1:0] wr_addr;
    copper_pkg::word_t                 wr_data;

    // read side, data follows the address by one cycle
    logic [copper_pkg::COP_AWIDTH-1:0] rd_addr;
    copper_pkg::word_t                 rd_data;

    // host block drives writes
    modport writer (
        output wr_en,
        output wr_addr,
        output wr_data
    );

    // engine presents an address and takes the word back
    modport reader (
        output rd_addr,
        input  rd_data
    );

    // memory side
    modport bank (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

/* logic/copper_bank.sv */
/*
 * copper program bank
 * one 16-bit half of the program memory, single write port and a
 * registered read port, filled with the END word at start-up
 */

`timescale 1ns/1ps

module copper_bank #(
    // 0 holds the high word, 1 holds the low word
    parameter int ODD_WORD = 0
) (
    input logic          clk,
    copper_mem_if.bank   mem
);

    // inferred block RAM
    copper_pkg::word_t ram [0:2**copper_pkg::COP_AWIDTH-1];

    // power-up content, every entry decodes as END with its partner bank
    initial begin
        for (int i = 0; i < 2**copper_pkg::COP_AWIDTH; i++) begin
            ram[i] = (ODD_WORD != 0) ? copper_pkg::END_WORD_ODD
                                     : copper_pkg::END_WORD_EVEN;
        end
    end

    // host write port
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // engine read port
    // a same-entry write in the same cycle is seen on the next read only
    always_ff @(posedge clk) begin
        mem.rd_data <= ram[mem.rd_addr];
    end

endmodule

/* logic/copper_host_apb.sv */
/*
 * copper APB host port
 * APB slave with one wait state, routes word writes to the even or odd
 * bank, holds the enable bit and returns control and status
 */

`timescale 1ns/1ps

module copper_host_apb (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [copper_pkg::APB_AWIDTH-1:0] paddr_i,
    input  copper_pkg::word_t                 pwdata_i,
    output copper_pkg::word_t                 prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    input  logic                              running_i,
    input  logic [copper_pkg::COP_AWIDTH-1:0] pc_i,
    output logic                              enable_o,
    copper_mem_if.writer                      even_mem,
    copper_mem_if.writer                      odd_mem
);

    logic                              access_first;
    logic                              access_last;
    logic                              mem_hit;
    logic                              ctrl_hit;
    logic                              status_hit;
    logic                              addr_err;
    copper_pkg::word_t                 rd_word;
    logic [1:0]                        wr_en_q;
    logic [copper_pkg::COP_AWIDTH-1:0] wr_addr_q;
    copper_pkg::word_t                 wr_data_q;
    logic                              enable_q;

    // first access cycle, pready still low
    assign access_first = psel_i && penable_i && !pready_o;
    // second access cycle, transfer completes at its closing edge
    assign access_last  = psel_i && penable_i && pready_o;

    // address decode
    assign mem_hit    = !paddr_i[copper_pkg::MEM_SEL_BIT];
    assign ctrl_hit   = (paddr_i == copper_pkg::CTRL_ADDR);
    assign status_hit = (paddr_i == copper_pkg::STATUS_ADDR);

    // memory is write only, anything outside the map is an error
    assign addr_err = mem_hit ? !pwrite_i : !(ctrl_hit || status_hit);

    // read mux for the register region
    always_comb begin
        rd_word = '0;
        if (ctrl_hit) begin
            rd_word[0] = enable_q;
        end else if (status_hit) begin
            rd_word[0]                        = running_i;
            rd_word[copper_pkg::COP_AWIDTH:1] = pc_i;
        end
    end

    // handshake, strobes and the control register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
            prdata_o  <= '0;
            wr_en_q   <= 2'b00;
            enable_q  <= 1'b0;
        end else begin
            // pready and its companions live for exactly one cycle
            pready_o  <= access_first;
            pslverr_o <= access_first && addr_err;
            prdata_o  <= (access_first && !pwrite_i) ? rd_word : '0;

            // strobe lands in the pready cycle so the bank commits with it
            wr_en_q[0] <= access_first && pwrite_i && mem_hit
                          && !paddr_i[copper_pkg::HALF_SEL_BIT];
            wr_en_q[1] <= access_first && pwrite_i && mem_hit
                          && paddr_i[copper_pkg::HALF_SEL_BIT];

            // control write commits with pready
            if (access_last && pwrite_i && ctrl_hit) begin
                enable_q <= pwdata_i[0];
            end
        end
    end

    // captured word and entry, shared by both banks
    always_ff @(posedge clk) begin
        if (access_first) begin
            wr_addr_q <= paddr_i[copper_pkg::COP_AWIDTH+1:2];
            wr_data_q <= pwdata_i;
        end
    end

    // even bank takes the high word
    assign even_mem.wr_en   = wr_en_q[0];
    assign even_mem.wr_addr = wr_addr_q;
    assign even_mem.wr_data = wr_data_q;

    // odd bank takes the low word
    assign odd_mem.wr_en   = wr_en_q[1];
    assign odd_mem.wr_addr = wr_addr_q;
    assign odd_mem.wr_data = wr_data_q;

    assign enable_o = enable_q;

endmodule

/* logic/copper_engine.sv */
/*
 * copper engine
 * fetches 32-bit instructions from both banks, issues register writes,
 * waits on the beam and halts on END until the next frame start
 */

`timescale 1ns/1ps

module copper_engine (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              enable_i,
    input  logic [copper_pkg::BEAM_WIDTH-1:0] h_pos_i,
    input  logic [copper_pkg::BEAM_WIDTH-1:0] v_pos_i,
    copper_mem_if.reader                      even_mem,
    copper_mem_if.reader                      odd_mem,
    output logic                              running_o,
    output logic [copper_pkg::COP_AWIDTH-1:0] pc_o,
    output logic                              reg_wr_o,
    output logic [copper_pkg::REG_AWIDTH-1:0] reg_addr_o,
    output copper_pkg::word_t                 reg_data_o
);

    // IDLE after reset, END or disable
    // FETCH puts the pc on the banks, EXEC sees the returned word
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_WAIT
    } state_e;

    state_e                            state_q;
    logic [copper_pkg::COP_AWIDTH-1:0] pc_q;
    copper_pkg::cop_instr_u            instr;
    logic [copper_pkg::BEAM_WIDTH-1:0] wait_v_q;
    logic [copper_pkg::BEAM_WIDTH-1:0] wait_h_q;
    logic                              frame_start;
    logic                              beam_past;
    logic                              exec_move;
    logic                              exec_wait;

    // both banks read the same entry
    assign even_mem.rd_addr = pc_q;
    assign odd_mem.rd_addr  = pc_q;

    // high word from the even bank, low word from the odd bank
    assign instr = {even_mem.rd_data, odd_mem.rd_data};

    // opcode bits are shared by both views
    assign exec_move = (state_q == ST_EXEC)
                       && (instr.move_view.op == copper_pkg::COP_MOVE);
    assign exec_wait = (state_q == ST_EXEC)
                       && (instr.move_view.op == copper_pkg::COP_WAIT);

    // first pixel of a frame
    assign frame_start = enable_i && (h_pos_i == '0) && (v_pos_i == '0);

    // beam is on a later line, or on the target line at or past the column
    assign beam_past = (v_pos_i > wait_v_q)
                       || ((v_pos_i == wait_v_q) && (h_pos_i >= wait_h_q));

    // sequencer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q  <= ST_IDLE;
            pc_q     <= '0;
            reg_wr_o <= 1'b0;
        end else begin
            // write pulse is one cycle wide
            reg_wr_o <= 1'b0;
            if (!enable_i) begin
                state_q <= ST_IDLE;
            end else if (frame_start) begin
                // restart wins over whatever is in flight
                pc_q    <= '0;
                state_q <= ST_FETCH;
            end else begin
                case (state_q)
                    ST_FETCH: begin
                        state_q <= ST_EXEC;
                    end
                    ST_EXEC: begin
                        case (instr.move_view.op)
                            copper_pkg::COP_MOVE: begin
                                reg_wr_o <= 1'b1;
                                pc_q     <= pc_q + 1'b1;
                                state_q  <= ST_FETCH;
                            end
                            copper_pkg::COP_WAIT: begin
                                state_q <= ST_WAIT;
                            end
                            copper_pkg::COP_END: begin
                                state_q <= ST_IDLE;
                            end
                            default: begin
                                // reserved opcode, step over it
                                pc_q    <= pc_q + 1'b1;
                                state_q <= ST_FETCH;
                            end
                        endcase
                    end
                    ST_WAIT: begin
                        if (beam_past) begin
                            pc_q    <= pc_q + 1'b1;
                            state_q <= ST_FETCH;
                        end
                    end
                    default: begin
                        // idle until the next frame start
                        state_q <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // register write payload, qualified by reg_wr_o
    always_ff @(posedge clk) begin
        if (exec_move) begin
            reg_addr_o <= instr.move_view.reg_addr;
            reg_data_o <= instr.move_view.data;
        end
    end

    // wait target, held so a host rewrite cannot move it
    always_ff @(posedge clk) begin
        if (exec_wait) begin
            wait_v_q <= instr.wait_view.v_pos;
            wait_h_q <= instr.wait_view.h_pos;
        end
    end

    assign running_o = (state_q != ST_IDLE);
    assign pc_o      = pc_q;

endmodule

/* logic/copper_top.sv */
/*
 * copper top level
 * two program banks, the APB host port and the copper engine
 */

`timescale 1ns/1ps

module copper_top (
    input  logic                              clk,
    input  logic                              reset_i,
    // APB host
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [copper_pkg::APB_AWIDTH-1:0] paddr_i,
    input  copper_pkg::word_t                 pwdata_i,
    output copper_pkg::word_t                 prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    // beam position from the video timing
    input  logic [copper_pkg::BEAM_WIDTH-1:0] h_pos_i,
    input  logic [copper_pkg::BEAM_WIDTH-1:0] v_pos_i,
    // video register writes
    output logic                              reg_wr_o,
    output logic [copper_pkg::REG_AWIDTH-1:0] reg_addr_o,
    output copper_pkg::word_t                 reg_data_o
);

    logic                              enable;
    logic                              running;
    logic [copper_pkg::COP_AWIDTH-1:0] pc;

    // index 0 is the even (high) bank, index 1 the odd (low) bank
    copper_mem_if mem_if [0:1] ();

    for (genvar i = 0; i < 2; i++) begin : g_bank
        copper_bank #(
            .ODD_WORD (i)
        ) bank_inst (
            .clk (clk),
            .mem (mem_if[i].bank)
        );
    end

    copper_host_apb host_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .running_i (running),
        .pc_i      (pc),
        .enable_o  (enable),
        .even_mem  (mem_if[0].writer),
        .odd_mem   (mem_if[1].writer)
    );

    copper_engine engine_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (enable),
        .h_pos_i    (h_pos_i),
        .v_pos_i    (v_pos_i),
        .even_mem   (mem_if[0].reader),
        .odd_mem    (mem_if[1].reader),
        .running_o  (running),
        .pc_o       (pc),
        .reg_wr_o   (reg_wr_o),
        .reg_addr_o (reg_addr_o),
        .reg_data_o (reg_data_o)
    );

endmodule

/* bench/copper_tb_sva.sv */
/*
 * copper engine assertions
 * shape of the register write strobe against running and reset
 */

`timescale 1ns/1ps

module copper_tb_sva (
    input logic clk,
    input logic reset_i,
    input logic running_o,
    input logic reg_wr_o
);

    // one MOVE gives one pulse, next fetch takes two cycles
    property single_cycle_write;
        @(posedge clk) disable iff (reset_i) reg_wr_o |=> !reg_wr_o;
    endproperty

    // no write once END or disable has stopped the engine
    property write_while_running;
        @(posedge clk) disable iff (reset_i) reg_wr_o |-> running_o;
    endproperty

    // strobe is clear straight out of reset
    property quiet_after_reset;
        @(posedge clk) reset_i |=> !reg_wr_o;
    endproperty

    a_single_cycle_write: assert property (single_cycle_write)
        else $error("register write strobe high in two cycles in a row");

    a_write_while_running: assert property (write_while_running)
        else $error("register write while the engine is not running");

    a_quiet_after_reset: assert property (quiet_after_reset)
        else $error("register write strobe high in the cycle after reset");

endmodule

/* bench/copper_tb.sv */
/*
 * copper testbench
 * loads random copper programs over APB, sweeps a small beam over each
 * frame and checks every register write against a reference model
 */

`timescale 1ns/1ps

module copper_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int H_PIXELS     = 64;
    localparam int V_LINES      = 16;
    localparam int FRAME_CYCLES = H_PIXELS * V_LINES;
    localparam int NUM_TESTS    = 6;

    logic                              clk;
    logic                              reset_i;
    logic                              psel_i;
    logic                              penable_i;
    logic                              pwrite_i;
    logic [copper_pkg::APB_AWIDTH-1:0] paddr_i;
    copper_pkg::word_t                 pwdata_i;
    copper_pkg::word_t                 prdata_o;
    logic                              pready_o;
    logic                              pslverr_o;
    logic [copper_pkg::BEAM_WIDTH-1:0] h_pos_i;
    logic [copper_pkg::BEAM_WIDTH-1:0] v_pos_i;
    logic                              reg_wr_o;
    logic [copper_pkg::REG_AWIDTH-1:0] reg_addr_o;
    copper_pkg::word_t                 reg_data_o;

    string       test_name;
    int          mismatch_count;
    int          other_count;
    int          writes_seen;
    logic [31:0] rng_state;
    // current program, one 32-bit instruction per entry
    logic [31:0] prog [$];
    // expected writes of one frame and the beam each must be past
    logic [copper_pkg::REG_AWIDTH-1:0] exp_addr [$];
    copper_pkg::word_t                 exp_data [$];
    logic [copper_pkg::BEAM_WIDTH-1:0] exp_v [$];
    logic [copper_pkg::BEAM_WIDTH-1:0] exp_h [$];
    int                                exp_end_pc;

    copper_top copper_top_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .h_pos_i    (h_pos_i),
        .v_pos_i    (v_pos_i),
        .reg_wr_o   (reg_wr_o),
        .reg_addr_o (reg_addr_o),
        .reg_data_o (reg_data_o)
    );

    bind copper_engine copper_tb_sva sva_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .running_o (running_o),
        .reg_wr_o  (reg_wr_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // beam sweep, one pixel per clock, moves just after the edge
    always @(posedge clk) begin
        #1;
        if (h_pos_i == H_PIXELS - 1) begin
            h_pos_i = '0;
            v_pos_i = (v_pos_i == V_LINES - 1) ? '0 : v_pos_i + 1'b1;
        end else begin
            h_pos_i = h_pos_i + 1'b1;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // true once the beam is on a later line, or at or past the column
    function automatic logic beam_after(input logic [9:0] v, input logic [9:0] h,
                                        input logic [9:0] tv, input logic [9:0] th);
        return (v > tv) || ((v == tv) && (h >= th));
    endfunction

    // walks the program from entry 0 and returns the entry holding END
    function automatic int ref_frame();
        logic [31:0] ins;
        logic [9:0]  tv;
        logic [9:0]  th;
        tv = '0;
        th = '0;
        exp_addr.delete();
        exp_data.delete();
        exp_v.delete();
        exp_h.delete();
        for (int i = 0; i < prog.size(); i++) begin
            ins = prog[i];
            case (ins[1:0])
                2'b01: begin
                    exp_addr.push_back(ins[15:2]);
                    exp_data.push_back(ins[31:16]);
                    exp_v.push_back(tv);
                    exp_h.push_back(th);
                end
                2'b10: begin
                    tv = ins[31:22];
                    th = ins[21:12];
                end
                2'b11: return i;
                default: begin
                    // reserved, no write
                end
            endcase
        end
        return int'(prog.size());
    endfunction

    // n random entries then END, wait targets kept in the first 12 lines
    function automatic void build_program(input int n, input int wait_pct, input int nop_pct);
        logic [31:0] r;
        int          sel;
        prog.delete();
        for (int i = 0; i < n; i++) begin
            sel = int'(next_random() % 100);
            r   = next_random();
            if (sel < wait_pct) begin
                prog.push_back({10'(r[31:16] % 12), 10'(r[15:0] % 64), 10'h000, 2'b10});
            end else if (sel < wait_pct + nop_pct) begin
                prog.push_back({r[31:2], 2'b00});
            end else begin
                prog.push_back({r[31:2], 2'b01});
            end
        end
        r = next_random();
        prog.push_back({r[31:2], 2'b11});
    endfunction

    task automatic log_mismatch(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        mismatch_count++;
        $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
    endtask

    task automatic fail_check(input string msg);
        other_count++;
        $display("%s: %s", test_name, msg);
    endtask

    // one APB transfer, entered and left 1 ns after a rising edge
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input copper_pkg::word_t wdata,
                              input copper_pkg::word_t exp_rdata, input logic exp_err);
        int                wait_cycles;
        copper_pkg::word_t rdata;
        logic              err;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #1;
        penable_i   = 1'b1;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!pready_o && wait_cycles < 16);
        rdata = prdata_o;
        err   = pslverr_o;
        assert (pready_o) else fail_check($sformatf("APB access to %h never completed", addr));
        assert (err == exp_err) else log_mismatch("pslverr", 32'(exp_err), 32'(err));
        if (!wr && !exp_err) begin
            assert (rdata == exp_rdata) else log_mismatch("prdata", 32'(exp_rdata), 32'(rdata));
        end
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    // engine stopped while both halves of every entry go in
    task automatic load_program();
        apb_access(1'b1, copper_pkg::CTRL_ADDR, 16'h0000, '0, 1'b0);
        for (int i = 0; i < prog.size(); i++) begin
            apb_access(1'b1, {1'b0, 9'(i), 2'b00}, prog[i][31:16], '0, 1'b0);
            apb_access(1'b1, {1'b0, 9'(i), 2'b10}, prog[i][15:0], '0, 1'b0);
        end
        apb_access(1'b1, copper_pkg::CTRL_ADDR, 16'h0001, '0, 1'b0);
    endtask

    // one frame from its first pixel into the last line
    // returns there so the host can stop the engine before the next frame start
    task automatic run_frame();
        exp_end_pc = ref_frame();
        do @(negedge clk); while (!(h_pos_i == '0 && v_pos_i == '0));
        // program is done long before the last line
        do @(negedge clk); while (v_pos_i != V_LINES - 1);
        @(posedge clk);
        #1;
        apb_access(1'b0, copper_pkg::STATUS_ADDR, '0, {6'b0, 9'(exp_end_pc), 1'b0}, 1'b0);
        assert (exp_addr.size() == 0)
            else fail_check($sformatf("%0d register writes never appeared", exp_addr.size()));
    endtask

    // compare each write pulse with the head of the expected list
    always @(negedge clk) begin
        if (!reset_i && reg_wr_o) begin
            writes_seen++;
            assert (exp_addr.size() > 0)
                else fail_check($sformatf("register write to %h that no instruction asked for",
                                          reg_addr_o));
            if (exp_addr.size() > 0) begin
                assert (reg_addr_o == exp_addr[0])
                    else log_mismatch("reg_addr", 32'(exp_addr[0]), 32'(reg_addr_o));
                assert (reg_data_o == exp_data[0])
                    else log_mismatch("reg_data", 32'(exp_data[0]), 32'(reg_data_o));
                assert (beam_after(v_pos_i, h_pos_i, exp_v[0], exp_h[0]))
                    else log_mismatch("beam", {12'h0, exp_v[0], exp_h[0]},
                                      {12'h0, v_pos_i, h_pos_i});
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_v.pop_front());
                void'(exp_h.pop_front());
            end
        end
    end

    // watchdog, four frames per test plus two spare
    initial begin
        #(CLK_PERIOD * FRAME_CYCLES * (NUM_TESTS * 4 + 2));
        $display("watchdog: the tests did not finish in time");
        $display("errors: mismatch %0d other %0d", mismatch_count, other_count + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        psel_i         = 1'b0;
        penable_i      = 1'b0;
        pwrite_i       = 1'b0;
        paddr_i        = '0;
        pwdata_i       = '0;
        h_pos_i        = '0;
        v_pos_i        = '0;
        rng_state      = 32'd17;
        mismatch_count = 0;
        other_count    = 0;
        writes_seen    = 0;
        test_name      = "reset";
        reset_i        = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;

        // empty memory decodes as END everywhere
        apb_access(1'b0, copper_pkg::CTRL_ADDR, '0, 16'h0000, 1'b0);
        apb_access(1'b0, copper_pkg::STATUS_ADDR, '0, 16'h0000, 1'b0);
        prog.delete();
        apb_access(1'b1, copper_pkg::CTRL_ADDR, 16'h0001, '0, 1'b0);
        run_frame();

        test_name = "apb_errors";
        apb_access(1'b0, 12'h010, '0, '0, 1'b1);
        apb_access(1'b0, 12'h808, '0, '0, 1'b1);
        apb_access(1'b1, 12'h900, 16'h0001, '0, 1'b1);
        apb_access(1'b1, copper_pkg::CTRL_ADDR, 16'h0000, '0, 1'b0);
        apb_access(1'b0, copper_pkg::CTRL_ADDR, '0, 16'h0000, 1'b0);
        apb_access(1'b1, copper_pkg::CTRL_ADDR, 16'h0001, '0, 1'b0);
        apb_access(1'b0, copper_pkg::CTRL_ADDR, '0, 16'h0001, 1'b0);

        // same list twice, END holds the engine in between
        test_name = "moves";
        build_program(8, 0, 0);
        load_program();
        run_frame();
        run_frame();

        test_name = "waits";
        build_program(12, 30, 0);
        load_program();
        run_frame();

        test_name = "rewrite";
        build_program(10, 0, 25);
        load_program();
        run_frame();

        $display("errors: mismatch %0d other %0d, register writes %0d",
                 mismatch_count, other_count, writes_seen);
        if (mismatch_count + other_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the copper testbench with Verilator, run it, check the log
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module copper_tb -f project.f -o copper_sim

./obj_dir/copper_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: passed"
else
    echo "run_sim: failed"
    exit 1
fi

/* project.f */
logic/copper_pkg.sv
logic/copper_mem_if.sv
logic/copper_bank.sv
logic/copper_host_apb.sv
logic/copper_engine.sv
logic/copper_top.sv
bench/copper_tb_sva.sv
bench/copper_tb.sv
